//--- hw/vc_dds_cfg.svh
`ifndef VC_DDS_CFG_SVH
`define VC_DDS_CFG_SVH

// Phase accumulator width
`define VC_PHASE_W 32

// Sample, shape, amplitude and DC offset width
`define VC_SAMPLE_W 16

// Full-scale current word, zero selects the top code
`define VC_FSC_W 10
`define VC_FSC_MAX {`VC_FSC_W{1'b1}}

// Phase offset word sits at the top of the phase
`define VC_PCW_W 10
`define VC_PCW_SHIFT 22

// Upper half of shape times amplitude
`define VC_SCALE_SHIFT 16

`endif

//--- hw/vc_dds_pkg.sv
`include "vc_dds_cfg.svh"

package vc_dds_pkg;

  typedef enum logic [1:0] {
    WAVE_DC       = 2'd0,             // Offset only
    WAVE_TRIANGLE = 2'd1,
    WAVE_SAWTOOTH = 2'd2
  } wave_mode_e;

  typedef struct packed {
    wave_mode_e                mode;
    logic [`VC_PHASE_W-1:0]    freq_word;  // Phase step per clock
    logic [`VC_PCW_W-1:0]      pcw;        // Start phase, top bits
    logic [`VC_SAMPLE_W-1:0]   amp;
    logic [`VC_SAMPLE_W-1:0]   dc_offset;
    logic [`VC_FSC_W-1:0]      fsc;
  } vc_cfg_t;

  typedef struct packed {
    logic                      valid;
    logic [`VC_PHASE_W-1:0]    phase;
    wave_mode_e                mode;
    logic [`VC_SAMPLE_W-1:0]   amp;
    logic [`VC_SAMPLE_W-1:0]   dc_offset;
  } phase_beat_t;

  typedef struct packed {
    logic                      valid;
    logic [`VC_SAMPLE_W-1:0]   shape;      // Unsigned wave shape
    logic [`VC_SAMPLE_W-1:0]   amp;
    logic [`VC_SAMPLE_W-1:0]   dc_offset;
  } shape_beat_t;

  typedef struct packed {
    logic                      valid;
    logic [`VC_SAMPLE_W-1:0]   scaled;
    logic [`VC_SAMPLE_W-1:0]   dc_offset;
  } scaled_beat_t;

endpackage

//--- hw/vc_dds_cfg_reg.sv
`timescale 1ns/1ns
`include "vc_dds_cfg.svh"

module vc_dds_cfg_reg
(
  input  logic                   clk_user_bufg,
  input  logic                   rst_glb,
  input  logic                   cfg_wr,       // One-cycle write strobe
  input  vc_dds_pkg::vc_cfg_t    cfg,
  output vc_dds_pkg::vc_cfg_t    active_cfg,
  output logic                   restart,
  output logic [`VC_FSC_W-1:0]   dac_fsc
);

  vc_dds_pkg::vc_cfg_t cfg_q;
  logic                restart_q;

  // A new word simply replaces the old one
  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      cfg_q     <= '0;
      restart_q <= 1'b0;
    end
    else
    begin
      restart_q <= cfg_wr;               // High in the cycle after the strobe
      if (cfg_wr)
      begin
        cfg_q <= cfg;
      end
    end
  end

  assign active_cfg = cfg_q;
  assign restart    = restart_q;

  // Zero word drives the DAC at full scale
  assign dac_fsc = (cfg_q.fsc == '0) ? `VC_FSC_MAX : cfg_q.fsc;

  // Only the three defined wave modes may be written
  mode_defined_a: assert property (
    @(posedge clk_user_bufg) disable iff (rst_glb)
    cfg_wr |-> (cfg.mode inside {vc_dds_pkg::WAVE_DC,
                                 vc_dds_pkg::WAVE_TRIANGLE,
                                 vc_dds_pkg::WAVE_SAWTOOTH})
  );

endmodule

//--- hw/vc_phase_accum.sv
`timescale 1ns/1ns
`include "vc_dds_cfg.svh"

module vc_phase_accum
(
  input  logic                       clk_user_bufg,
  input  logic                       rst_glb,
  input  vc_dds_pkg::vc_cfg_t        active_cfg,
  input  logic                       restart,     // Reload start phase
  output vc_dds_pkg::phase_beat_t    beat
);

  logic                       running;          // Set by first restart
  logic [`VC_PHASE_W-1:0]     phase_q;
  vc_dds_pkg::wave_mode_e     mode_q;
  logic [`VC_SAMPLE_W-1:0]    amp_q;
  logic [`VC_SAMPLE_W-1:0]    dc_offset_q;
  logic [`VC_PHASE_W-1:0]     start_phase;

  // Phase offset word lands in the top bits
  assign start_phase = {active_cfg.pcw, {`VC_PCW_SHIFT{1'b0}}};

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      running <= 1'b0;
      phase_q <= '0;
    end
    else
    begin
      if (restart)
      begin
        running <= 1'b1;
        phase_q <= start_phase;
      end
      else
      begin
        phase_q <= phase_q + active_cfg.freq_word;  // Wraps mod 2^32
      end
    end
  end

  // Each beat carries the settings it was made with
  always_ff @(posedge clk_user_bufg)
  begin
    mode_q      <= active_cfg.mode;
    amp_q       <= active_cfg.amp;
    dc_offset_q <= active_cfg.dc_offset;
  end

  assign beat = '{
    valid:     running,
    phase:     phase_q,
    mode:      mode_q,
    amp:       amp_q,
    dc_offset: dc_offset_q
  };

  // Once streaming, only a reset stops the output
  running_sticky_a: assert property (
    @(posedge clk_user_bufg) disable iff (rst_glb)
    running |=> running
  );

endmodule

//--- hw/vc_wave_shaper.sv
`timescale 1ns/1ns
`include "vc_dds_cfg.svh"

module vc_wave_shaper
(
  input  logic                       clk_user_bufg,
  input  logic                       rst_glb,
  input  vc_dds_pkg::phase_beat_t    beat_in,
  output vc_dds_pkg::shape_beat_t    beat_out
);

  logic                       phase_msb;
  logic [`VC_SAMPLE_W-1:0]    tri_ramp;        // Phase below the MSB
  logic [`VC_SAMPLE_W-1:0]    saw_ramp;
  logic [`VC_SAMPLE_W-1:0]    shape_d;
  logic                       valid_q;
  logic [`VC_SAMPLE_W-1:0]    shape_q;
  logic [`VC_SAMPLE_W-1:0]    amp_q;
  logic [`VC_SAMPLE_W-1:0]    dc_offset_q;

  assign phase_msb = beat_in.phase[`VC_PHASE_W-1];
  assign tri_ramp  = beat_in.phase[`VC_PHASE_W-2 -: `VC_SAMPLE_W];
  assign saw_ramp  = beat_in.phase[`VC_PHASE_W-1 -: `VC_SAMPLE_W];

  always_comb
  begin
    case (beat_in.mode)
      vc_dds_pkg::WAVE_TRIANGLE:
      begin
        // Rising half, then mirrored falling half
        shape_d = phase_msb ? ~tri_ramp : tri_ramp;
      end
      vc_dds_pkg::WAVE_SAWTOOTH:
      begin
        shape_d = saw_ramp;
      end
      default:
      begin
        shape_d = '0;                         // DC mode, offset only
      end
    endcase
  end

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= beat_in.valid;
    end
  end

  always_ff @(posedge clk_user_bufg)
  begin
    shape_q     <= shape_d;
    amp_q       <= beat_in.amp;
    dc_offset_q <= beat_in.dc_offset;
  end

  assign beat_out = '{
    valid:     valid_q,
    shape:     shape_q,
    amp:       amp_q,
    dc_offset: dc_offset_q
  };

endmodule

//--- hw/vc_amp_offset.sv
`timescale 1ns/1ns
`include "vc_dds_cfg.svh"

module vc_amp_offset
(
  input  logic                       clk_user_bufg,
  input  logic                       rst_glb,
  input  vc_dds_pkg::shape_beat_t    beat_in,
  output logic [`VC_SAMPLE_W-1:0]    sample,
  output logic                       sample_valid
);

  logic [2*`VC_SAMPLE_W-1:0]  product;          // Full shape times amp
  logic                       scale_valid_q;
  logic [`VC_SAMPLE_W-1:0]    scaled_q;
  logic [`VC_SAMPLE_W-1:0]    offset_q;
  vc_dds_pkg::scaled_beat_t   scaled_beat;
  logic [`VC_SAMPLE_W:0]      sum;              // One carry bit
  logic                       sample_valid_q;
  logic [`VC_SAMPLE_W-1:0]    sample_q;

  assign product = {{`VC_SAMPLE_W{1'b0}}, beat_in.shape} * {{`VC_SAMPLE_W{1'b0}}, beat_in.amp};

  // First stage keeps the upper half of the product
  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      scale_valid_q <= 1'b0;
    end
    else
    begin
      scale_valid_q <= beat_in.valid;
    end
  end

  always_ff @(posedge clk_user_bufg)
  begin
    scaled_q <= product[`VC_SCALE_SHIFT +: `VC_SAMPLE_W];
    offset_q <= beat_in.dc_offset;
  end

  assign scaled_beat = '{
    valid:     scale_valid_q,
    scaled:    scaled_q,
    dc_offset: offset_q
  };

  // Second stage adds the DC level and clips at the top code
  assign sum = {1'b0, scaled_beat.dc_offset} + {1'b0, scaled_beat.scaled};

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      sample_valid_q <= 1'b0;
    end
    else
    begin
      sample_valid_q <= scaled_beat.valid;
    end
  end

  always_ff @(posedge clk_user_bufg)
  begin
    sample_q <= sum[`VC_SAMPLE_W] ? {`VC_SAMPLE_W{1'b1}} : sum[`VC_SAMPLE_W-1:0];
  end

  assign sample       = sample_q;
  assign sample_valid = sample_valid_q;

  // Scaling only adds on top of the offset of the same beat
  above_offset_a: assert property (
    @(posedge clk_user_bufg) disable iff (rst_glb)
    sample_valid |-> (sample >= $past(scaled_beat.dc_offset))
  );

endmodule

//--- hw/vc_dds_top.sv
`timescale 1ns/1ns
`include "vc_dds_cfg.svh"

module vc_dds_top
(
  input  logic                    clk_user_bufg,
  input  logic                    rst_glb,
  input  logic                    cfg_wr,          // Config write strobe
  input  vc_dds_pkg::vc_cfg_t     cfg,
  output logic [`VC_SAMPLE_W-1:0] sample,          // To laser drive DAC
  output logic                    sample_valid,
  output logic [`VC_FSC_W-1:0]    dac_fsc          // DAC full-scale current
);

  vc_dds_pkg::vc_cfg_t       active_cfg;
  logic                      restart;
  vc_dds_pkg::phase_beat_t   phase_beat;
  vc_dds_pkg::shape_beat_t   shape_beat;

  vc_dds_cfg_reg u_cfg_reg (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .cfg_wr        (cfg_wr),
    .cfg           (cfg),
    .active_cfg    (active_cfg),
    .restart       (restart),
    .dac_fsc       (dac_fsc)
  );

  vc_phase_accum u_phase_accum (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .active_cfg    (active_cfg),
    .restart       (restart),
    .beat          (phase_beat)
  );

  vc_wave_shaper u_wave_shaper (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .beat_in       (phase_beat),
    .beat_out      (shape_beat)
  );

  // Two register stages, scale then offset
  vc_amp_offset u_amp_offset (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .beat_in       (shape_beat),
    .sample        (sample),
    .sample_valid  (sample_valid)
  );

endmodule

//--- testbench/vc_dds_tb_table.svh
`ifndef VC_DDS_TB_TABLE_SVH
`define VC_DDS_TB_TABLE_SVH

// Columns: mode, freq_word, pcw, amp, dc_offset, fsc, samples checked from E4,
// random flag (amp and dc_offset then come from $urandom)

localparam int NUM_ROWS = 7;

row_t rows [NUM_ROWS];

task automatic load_table();
  // DC level only, amplitude has no effect
  rows[0] = '{vc_dds_pkg::WAVE_DC, 32'h0100_0000, 10'h000,
              16'h8000, 16'h1234, 10'd512, 8, 1'b0};
  // Triangle from a nonzero start, 32 samples per wrap
  rows[1] = '{vc_dds_pkg::WAVE_TRIANGLE, 32'h0800_0000, 10'h155,
              16'hFFFF, 16'h0040, 10'd0, 40, 1'b0};
  // Sawtooth with random level
  rows[2] = '{vc_dds_pkg::WAVE_SAWTOOTH, 32'h0345_6789, 10'h07F,
              16'h0000, 16'h0000, 10'd300, 24, 1'b1};
  // Reconfigure a running sawtooth
  rows[3] = '{vc_dds_pkg::WAVE_SAWTOOTH, 32'h1234_5678, 10'h3C0,
              16'h0000, 16'h0000, 10'd1, 12, 1'b1};
  // Top of the ramp clips
  rows[4] = '{vc_dds_pkg::WAVE_SAWTOOTH, 32'h1000_0000, 10'h000,
              16'hFFFF, 16'hF000, 10'd0, 20, 1'b0};
  rows[5] = '{vc_dds_pkg::WAVE_TRIANGLE, 32'h0400_0000, 10'h200,
              16'hFFFF, 16'hFF00, 10'h3FF, 24, 1'b0};
  // Full-scale DC
  rows[6] = '{vc_dds_pkg::WAVE_DC, 32'hDEAD_BEEF, 10'h3FF,
              16'hFFFF, 16'hFFFF, 10'd0, 6, 1'b0};
endtask

`endif

//--- testbench/vc_dds_tb.sv
`timescale 1ns/1ns
`include "vc_dds_cfg.svh"

module vc_dds_tb;

  typedef struct packed {
    vc_dds_pkg::wave_mode_e    mode;
    logic [31:0]               freq_word;
    logic [9:0]                pcw;
    logic [15:0]               amp;
    logic [15:0]               dc_offset;
    logic [9:0]                fsc;
    int                        count;       // Samples checked from E4 on
    logic                      rand_level;
  } row_t;

  `include "vc_dds_tb_table.svh"

  localparam int VALID_TIMEOUT = 20;         // Cycles allowed for first valid

  logic                  clk_user_bufg = 1'b0;
  logic                  rst_glb;
  logic                  cfg_wr;
  vc_dds_pkg::vc_cfg_t   cfg;
  logic [15:0]           sample;
  logic                  sample_valid;
  logic [9:0]            dac_fsc;

  // Reference model state
  vc_dds_pkg::vc_cfg_t   m_cfg;
  vc_dds_pkg::vc_cfg_t   pend_cfg;
  logic [31:0]           m_phase;            // Phase of the sample on the output
  logic                  m_valid;
  logic [9:0]            m_fsc;
  int                    switch_cnt;         // Edges until the new config shows
  int                    cur_row;
  vc_dds_pkg::vc_cfg_t   idle_cfg;

  vc_dds_top uut (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .cfg_wr        (cfg_wr),
    .cfg           (cfg),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .dac_fsc       (dac_fsc)
  );

  always #5 clk_user_bufg = ~clk_user_bufg;

  task automatic report_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  // Shape, scale and offset of one phase value
  function automatic logic [15:0] expected_sample(input vc_dds_pkg::vc_cfg_t c,
                                                  input logic [31:0] phase);
    logic [15:0] shape;
    logic [31:0] product;
    logic [16:0] total;
    case (c.mode)
      vc_dds_pkg::WAVE_TRIANGLE:
      begin
        shape = phase[31] ? ~phase[30:15] : phase[30:15];
      end
      vc_dds_pkg::WAVE_SAWTOOTH:
      begin
        shape = phase[31:16];
      end
      default:
      begin
        shape = 16'h0000;
      end
    endcase
    product = {16'h0000, shape} * {16'h0000, c.amp};
    total = {1'b0, c.dc_offset} + {1'b0, product[31:16]};
    if (total[16])
    begin
      return 16'hFFFF;                       // Clip at the top code
    end
    return total[15:0];
  endfunction

  // One clock edge of the model
  task automatic advance_model();
    if (switch_cnt == 1)
    begin
      m_cfg      = pend_cfg;
      m_phase    = {pend_cfg.pcw, {`VC_PCW_SHIFT{1'b0}}};
      m_valid    = 1'b1;
      switch_cnt = 0;
    end
    else
    begin
      if (switch_cnt == 5)
      begin
        m_fsc = (pend_cfg.fsc == '0) ? 10'h3FF : pend_cfg.fsc;   // Edge E0
      end
      if (switch_cnt > 0)
      begin
        switch_cnt--;
      end
      if (m_valid)
      begin
        m_phase = m_phase + m_cfg.freq_word;
      end
    end
  endtask

  // Drive on the rising edge and check at the falling edge
  task automatic run_cycle(input logic do_wr, input vc_dds_pkg::vc_cfg_t c,
                           input logic skip_valid);
    logic [15:0] exp_sample;
    @(posedge clk_user_bufg);
    cfg_wr <= do_wr;
    if (do_wr)
    begin
      cfg <= c;
    end
    advance_model();
    if (do_wr)
    begin
      pend_cfg   = c;
      switch_cnt = 5;
    end
    @(negedge clk_user_bufg);
    if (!skip_valid)
    begin
      assert (sample_valid == m_valid)
      else report_error($sformatf("row %0d sample_valid %0b expected %0b",
                                  cur_row, sample_valid, m_valid));
    end
    if (m_valid && sample_valid)
    begin
      exp_sample = expected_sample(m_cfg, m_phase);
      assert (sample == exp_sample)
      else report_error($sformatf("row %0d phase %h sample %h expected %h",
                                  cur_row, m_phase, sample, exp_sample));
    end
    assert (dac_fsc == m_fsc)
    else report_error($sformatf("row %0d dac_fsc %0d expected %0d",
                                cur_row, dac_fsc, m_fsc));
  endtask

  task automatic wait_first_valid();
    int n;
    n = 0;
    while (!sample_valid)
    begin
      if (n >= VALID_TIMEOUT)
      begin
        $display("Timeout: sample_valid never rose after the first configuration write");
        $display("Checks failed");
        $fatal(1);
      end
      run_cycle(1'b0, idle_cfg, 1'b1);
      n++;
    end
    // Valid must show at E4 which is the fifth edge after the strobe edge
    assert (n == 5)
    else report_error($sformatf("sample_valid rose %0d edges after the strobe", n));
  endtask

  task automatic apply_row(input int r);
    row_t                row;
    vc_dds_pkg::vc_cfg_t c;
    logic [31:0]         rnd;
    row         = rows[r];
    c.mode      = row.mode;
    c.freq_word = row.freq_word;
    c.pcw       = row.pcw;
    c.amp       = row.amp;
    c.dc_offset = row.dc_offset;
    c.fsc       = row.fsc;
    if (row.rand_level)
    begin
      rnd         = $urandom;
      c.amp       = rnd[15:0];
      c.dc_offset = rnd[31:16];
    end
    cur_row = r;
    run_cycle(1'b1, c, 1'b0);
    if (r == 0)
    begin
      wait_first_valid();
      repeat (row.count - 1) run_cycle(1'b0, idle_cfg, 1'b0);
    end
    else
    begin
      // Old beats drain for four edges before the new stream
      repeat (4 + row.count) run_cycle(1'b0, idle_cfg, 1'b0);
    end
  endtask

  initial
  begin
    void'($urandom(32'h7d71_7193));
    rst_glb    = 1'b1;
    cfg_wr     = 1'b0;
    cfg        = '0;
    idle_cfg   = '0;
    m_cfg      = '0;
    pend_cfg   = '0;
    m_phase    = '0;
    m_valid    = 1'b0;
    m_fsc      = 10'h3FF;                    // Zero config means full scale
    switch_cnt = 0;
    cur_row    = -1;
    load_table();
    repeat (3) @(posedge clk_user_bufg);
    rst_glb <= 1'b0;
    // Nothing streams yet after reset
    repeat (4) run_cycle(1'b0, idle_cfg, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      apply_row(r);
    end
    repeat (3) run_cycle(1'b0, idle_cfg, 1'b0);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- vc_dds_top.f
+incdir+hw
+incdir+testbench
hw/vc_dds_pkg.sv
hw/vc_dds_cfg_reg.sv
hw/vc_phase_accum.sv
hw/vc_wave_shaper.sv
hw/vc_amp_offset.sv
hw/vc_dds_top.sv
testbench/vc_dds_tb.sv

//--- Makefile
SIM := obj_dir/vc_dds_sim

.PHONY: build run clean

build: $(SIM)

$(SIM): vc_dds_top.f hw/*.sv hw/*.svh testbench/*.sv testbench/*.svh
	verilator --binary --timing --assert -f vc_dds_top.f \
		--top-module vc_dds_tb -o vc_dds_sim

# The run passes only when the simulator printed the pass line
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
